/* hdl/cpu_pkg.sv */
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // operation applied by the ALU. pass_b forwards operand b for lui.
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sll, alu_srl, alu_pass_b
  } alu_op_t;

  typedef enum logic [2:0] {
    op_alu,
    op_lui,
    op_jal,
    op_load,
    op_store,
    op_branch_eq,
    op_branch_ne,
    op_illegal
  } opclass_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_execute,
    st_memory,
    st_writeback
  } state_t;

  typedef struct packed {
    opclass_t opclass;
    alu_op_t  alu_op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     use_imm;
    word_t    imm;
    logic     writes_rd;
  } decoded_t;

  typedef struct packed {
    word_t result;
    word_t mem_addr;
    word_t store_data;
    word_t next_pc;
    word_t link;
  } exec_t;

endpackage

/* hdl/decoder.sv */
`timescale 1ns/10ps

module decoder (
  input  cpu_pkg::word_t    instr,
  output cpu_pkg::decoded_t dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  cpu_pkg::word_t imm_i;
  cpu_pkg::word_t imm_s;
  cpu_pkg::word_t imm_b;
  cpu_pkg::word_t imm_u;
  cpu_pkg::word_t imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    cpu_pkg::decoded_t d;
    d.opclass = cpu_pkg::op_illegal;
    d.alu_op = cpu_pkg::alu_add;
    d.rd = instr[11:7];
    d.rs1 = instr[19:15];
    d.rs2 = instr[24:20];
    d.use_imm = 1'b0;
    d.imm = '0;
    d.writes_rd = 1'b0;
    case (opcode)
      7'b0110111: begin
        d.opclass = cpu_pkg::op_lui;
        d.alu_op = cpu_pkg::alu_pass_b;
        d.use_imm = 1'b1;
        d.imm = imm_u;
        d.writes_rd = 1'b1;
      end
      7'b1101111: begin
        d.opclass = cpu_pkg::op_jal;
        d.imm = imm_j;
        d.writes_rd = 1'b1;
      end
      7'b0010011: begin
        d.use_imm = 1'b1;
        d.imm = imm_i;
        d.opclass = cpu_pkg::op_alu;
        d.writes_rd = 1'b1;
        case (funct3)
          3'b000: d.alu_op = cpu_pkg::alu_add;
          3'b010: d.alu_op = cpu_pkg::alu_slt;
          3'b100: d.alu_op = cpu_pkg::alu_xor;
          3'b110: d.alu_op = cpu_pkg::alu_or;
          3'b111: d.alu_op = cpu_pkg::alu_and;
          default: begin
            d.opclass = cpu_pkg::op_illegal;
            d.writes_rd = 1'b0;
          end
        endcase
      end
      7'b0110011: begin
        d.opclass = cpu_pkg::op_alu;
        d.writes_rd = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: d.alu_op = cpu_pkg::alu_add;
          10'b0100000_000: d.alu_op = cpu_pkg::alu_sub;
          10'b0000000_001: d.alu_op = cpu_pkg::alu_sll;
          10'b0000000_010: d.alu_op = cpu_pkg::alu_slt;
          10'b0000000_100: d.alu_op = cpu_pkg::alu_xor;
          10'b0000000_101: d.alu_op = cpu_pkg::alu_srl;
          10'b0000000_110: d.alu_op = cpu_pkg::alu_or;
          10'b0000000_111: d.alu_op = cpu_pkg::alu_and;
          default: begin
            d.opclass = cpu_pkg::op_illegal;
            d.writes_rd = 1'b0;
          end
        endcase
      end
      7'b0000011: begin
        if (funct3 == 3'b010) begin
          d.opclass = cpu_pkg::op_load;
          d.writes_rd = 1'b1;
        end
        d.imm = imm_i;
      end
      7'b0100011: begin
        if (funct3 == 3'b010) begin
          d.opclass = cpu_pkg::op_store;
        end
        d.imm = imm_s;
      end
      7'b1100011: begin
        d.imm = imm_b;
        if (funct3 == 3'b000) begin
          d.opclass = cpu_pkg::op_branch_eq;
        end else if (funct3 == 3'b001) begin
          d.opclass = cpu_pkg::op_branch_ne;
        end
      end
      default: d.opclass = cpu_pkg::op_illegal;
    endcase
    // x0 is never written.
    if (d.rd == 5'd0) begin
      d.writes_rd = 1'b0;
    end
    dec = d;
  end

  always_comb begin
    assert final (!(dec.opclass == cpu_pkg::op_illegal && dec.writes_rd));
  end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/10ps

module register_file (
  input  logic              clock,
  input  logic              rst,
  input  cpu_pkg::reg_idx_t rs1,
  input  cpu_pkg::reg_idx_t rs2,
  input  cpu_pkg::reg_idx_t waddr,
  input  logic              we,
  input  cpu_pkg::word_t    wdata,
  output cpu_pkg::word_t    rs1_data,
  output cpu_pkg::word_t    rs2_data
);

  cpu_pkg::word_t regs [1:31];

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 has no storage and reads as zero.
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/10ps

module execute_unit (
  input  logic              clock,
  input  logic              rst,
  input  cpu_pkg::word_t    pc,
  input  cpu_pkg::decoded_t dec,
  input  cpu_pkg::word_t    rs1_data,
  input  cpu_pkg::word_t    rs2_data,
  input  logic              latch,
  output cpu_pkg::exec_t    ex
);

  cpu_pkg::word_t op_b;
  cpu_pkg::word_t alu_result;
  logic [4:0] shamt;
  logic taken;
  cpu_pkg::exec_t ex_comb;

  assign op_b = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      cpu_pkg::alu_add:    alu_result = rs1_data + op_b;
      cpu_pkg::alu_sub:    alu_result = rs1_data - op_b;
      cpu_pkg::alu_and:    alu_result = rs1_data & op_b;
      cpu_pkg::alu_or:     alu_result = rs1_data | op_b;
      cpu_pkg::alu_xor:    alu_result = rs1_data ^ op_b;
      cpu_pkg::alu_slt:    alu_result = {31'b0, $signed(rs1_data) < $signed(op_b)};
      cpu_pkg::alu_sll:    alu_result = rs1_data << shamt;
      cpu_pkg::alu_srl:    alu_result = rs1_data >> shamt;
      cpu_pkg::alu_pass_b: alu_result = op_b;
      default:             alu_result = '0;
    endcase
  end

  assign taken = (dec.opclass == cpu_pkg::op_branch_eq && rs1_data == rs2_data) ||
                 (dec.opclass == cpu_pkg::op_branch_ne && rs1_data != rs2_data);

  always_comb begin
    ex_comb.result = alu_result;
    ex_comb.mem_addr = rs1_data + dec.imm;
    ex_comb.store_data = rs2_data;
    ex_comb.link = pc + 32'd4;
    // jal and taken branches are both pc relative.
    if (taken || dec.opclass == cpu_pkg::op_jal) begin
      ex_comb.next_pc = pc + dec.imm;
    end else begin
      ex_comb.next_pc = pc + 32'd4;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      ex <= '0;
    end else if (latch) begin
      ex <= ex_comb;
    end
  end

endmodule

/* hdl/result_unit.sv */
`timescale 1ns/10ps

module result_unit (
  input  logic              clock,
  input  logic              rst,
  input  cpu_pkg::decoded_t dec,
  input  cpu_pkg::exec_t    ex,
  input  logic              mem_phase,
  input  logic              wb_phase,
  output logic              dmemory_valid,
  output cpu_pkg::word_t    dmemory_addr,
  output cpu_pkg::word_t    dmemory_wdata,
  output logic [3:0]        dmemory_wstrb,
  input  cpu_pkg::word_t    dmemory_rdata,
  input  logic              dmemory_ready,
  output logic              mem_done,
  output logic              we,
  output cpu_pkg::reg_idx_t waddr,
  output cpu_pkg::word_t    wdata
);

  logic is_store;
  cpu_pkg::word_t load_data;

  assign is_store = dec.opclass == cpu_pkg::op_store;

  // the memory state is entered only for loads and stores.
  assign dmemory_valid = mem_phase;
  assign dmemory_addr = ex.mem_addr;
  assign dmemory_wdata = is_store ? ex.store_data : '0;
  assign dmemory_wstrb = is_store ? 4'hf : 4'h0;
  assign mem_done = mem_phase && dmemory_ready;

  always_ff @(posedge clock) begin
    if (rst) begin
      load_data <= '0;
    end else if (mem_done && dec.opclass == cpu_pkg::op_load) begin
      load_data <= dmemory_rdata;
    end
  end

  assign we = wb_phase && dec.writes_rd;
  assign waddr = dec.rd;

  always_comb begin
    case (dec.opclass)
      cpu_pkg::op_load: wdata = load_data;
      cpu_pkg::op_jal:  wdata = ex.link;
      default:          wdata = ex.result;
    endcase
  end

  dmemory_addr_stable : assert property (@(posedge clock) disable iff (rst)
    dmemory_valid && !dmemory_ready |=> $stable(dmemory_addr));

endmodule

/* hdl/sequencer.sv */
`timescale 1ns/10ps

module sequencer #(
  parameter cpu_pkg::word_t reset_pc = '0
) (
  input  logic              clock,
  input  logic              rst,
  output logic              imemory_valid,
  output cpu_pkg::word_t    imemory_addr,
  input  cpu_pkg::word_t    imemory_rdata,
  input  logic              imemory_ready,
  input  cpu_pkg::decoded_t dec,
  input  cpu_pkg::exec_t    ex,
  input  logic              mem_done,
  output cpu_pkg::word_t    instr,
  output cpu_pkg::word_t    pc,
  output logic              latch,
  output logic              mem_phase,
  output logic              wb_phase
);

  cpu_pkg::state_t state;
  logic is_mem;

  assign is_mem = dec.opclass == cpu_pkg::op_load || dec.opclass == cpu_pkg::op_store;

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= cpu_pkg::st_fetch;
      pc <= reset_pc;
      instr <= '0;
      imemory_valid <= 1'b0;
    end else begin
      case (state)
        cpu_pkg::st_fetch: begin
          if (imemory_valid && imemory_ready) begin
            instr <= imemory_rdata;
            imemory_valid <= 1'b0;
            state <= cpu_pkg::st_decode;
          end else begin
            imemory_valid <= 1'b1;
          end
        end
        cpu_pkg::st_decode: begin
          state <= cpu_pkg::st_execute;
        end
        cpu_pkg::st_execute: begin
          if (is_mem) begin
            state <= cpu_pkg::st_memory;
          end else begin
            state <= cpu_pkg::st_writeback;
          end
        end
        cpu_pkg::st_memory: begin
          if (mem_done) begin
            state <= cpu_pkg::st_writeback;
          end
        end
        cpu_pkg::st_writeback: begin
          // request the next instruction right away.
          pc <= ex.next_pc;
          imemory_valid <= 1'b1;
          state <= cpu_pkg::st_fetch;
        end
        default: begin
          state <= cpu_pkg::st_fetch;
        end
      endcase
    end
  end

  assign imemory_addr = pc;
  assign latch = state == cpu_pkg::st_execute;
  assign mem_phase = state == cpu_pkg::st_memory;
  assign wb_phase = state == cpu_pkg::st_writeback;

  imemory_valid_held : assert property (@(posedge clock) disable iff (rst)
    imemory_valid && !imemory_ready |=> imemory_valid && $stable(imemory_addr));

endmodule

/* hdl/cpu.sv */
`timescale 1ns/10ps

module cpu #(
  parameter cpu_pkg::word_t reset_pc = '0
) (
  input  logic           clock,
  input  logic           rst,
  output logic           imemory_valid,
  output cpu_pkg::word_t imemory_addr,
  output cpu_pkg::word_t imemory_wdata,
  output logic [3:0]     imemory_wstrb,
  input  cpu_pkg::word_t imemory_rdata,
  input  logic           imemory_ready,
  output logic           dmemory_valid,
  output cpu_pkg::word_t dmemory_addr,
  output cpu_pkg::word_t dmemory_wdata,
  output logic [3:0]     dmemory_wstrb,
  input  cpu_pkg::word_t dmemory_rdata,
  input  logic           dmemory_ready
);

  cpu_pkg::word_t instr;
  cpu_pkg::word_t pc;
  cpu_pkg::decoded_t dec;
  cpu_pkg::exec_t ex;
  cpu_pkg::word_t rs1_data;
  cpu_pkg::word_t rs2_data;
  cpu_pkg::reg_idx_t waddr;
  cpu_pkg::word_t wdata;
  logic we;
  logic latch;
  logic mem_phase;
  logic wb_phase;
  logic mem_done;

  // the instruction port only reads.
  assign imemory_wdata = '0;
  assign imemory_wstrb = 4'h0;

  sequencer #(
    .reset_pc (reset_pc)
  ) sequencer_comp (
    .clock         (clock),
    .rst           (rst),
    .imemory_valid (imemory_valid),
    .imemory_addr  (imemory_addr),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .dec           (dec),
    .ex            (ex),
    .mem_done      (mem_done),
    .instr         (instr),
    .pc            (pc),
    .latch         (latch),
    .mem_phase     (mem_phase),
    .wb_phase      (wb_phase)
  );

  decoder decoder_comp (
    .instr (instr),
    .dec   (dec)
  );

  register_file register_file_comp (
    .clock    (clock),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .waddr    (waddr),
    .we       (we),
    .wdata    (wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_unit execute_unit_comp (
    .clock    (clock),
    .rst      (rst),
    .pc       (pc),
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .latch    (latch),
    .ex       (ex)
  );

  result_unit result_unit_comp (
    .clock         (clock),
    .rst           (rst),
    .dec           (dec),
    .ex            (ex),
    .mem_phase     (mem_phase),
    .wb_phase      (wb_phase),
    .dmemory_valid (dmemory_valid),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb),
    .dmemory_rdata (dmemory_rdata),
    .dmemory_ready (dmemory_ready),
    .mem_done      (mem_done),
    .we            (we),
    .waddr         (waddr),
    .wdata         (wdata)
  );

endmodule

/* bench/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;

  localparam logic [31:0] reset_pc = 32'h0000_0040;
  localparam int num_rows = 19;
  localparam int cycle_limit = 300 * num_rows;

  typedef enum logic [3:0] {
    t_add, t_sub, t_and, t_or, t_xor, t_slt, t_sll, t_srl,
    t_addi, t_andi, t_ori, t_xori, t_slti, t_beq, t_bne
  } test_op_t;

  typedef struct packed {
    test_op_t    op;
    logic [31:0] a;
    logic [31:0] b;
    logic        load;
  } row_t;

  logic clock;
  logic rst;
  logic imemory_valid;
  logic [31:0] imemory_addr;
  logic [31:0] imemory_wdata;
  logic [3:0] imemory_wstrb;
  logic [31:0] imemory_rdata;
  logic imemory_ready;
  logic dmemory_valid;
  logic [31:0] dmemory_addr;
  logic [31:0] dmemory_wdata;
  logic [3:0] dmemory_wstrb;
  logic [31:0] dmemory_rdata;
  logic dmemory_ready;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  row_t rows [0:num_rows-1];
  integer seed = 32'hda77;
  int error_count;
  int failed_tests;
  int cycles;
  int prog_pos;
  int imem_wait;
  int dmem_wait;
  logic [31:0] imem_req_addr;
  logic [31:0] dmem_req_addr;
  logic [31:0] dmem_req_wdata;
  logic store_seen;
  logic [31:0] store_addr;
  logic [31:0] store_data;
  logic [3:0] store_strb;

  cpu #(
    .reset_pc (reset_pc)
  ) dut0 (
    .clock         (clock),
    .rst           (rst),
    .imemory_valid (imemory_valid),
    .imemory_addr  (imemory_addr),
    .imemory_wdata (imemory_wdata),
    .imemory_wstrb (imemory_wstrb),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .dmemory_valid (dmemory_valid),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb),
    .dmemory_rdata (dmemory_rdata),
    .dmemory_ready (dmemory_ready)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: the core stopped making progress after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  function automatic int draw_wait();
    int r;
    r = $random(seed);
    return r & 3;
  endfunction

  function automatic row_t make_row(input test_op_t op, input logic [31:0] a,
                                    input logic [31:0] b, input logic load);
    row_t r;
    r.op = op;
    r.a = a;
    r.b = b;
    r.load = load;
    return r;
  endfunction

  // the rule of each operation, taken from the RV32I definitions.
  function automatic logic [31:0] expected_result(input row_t r);
    logic taken;
    logic [31:0] imm;
    taken = 1'b0;
    // an immediate operand is the low 12 bits of b, sign extended.
    imm = {{20{r.b[11]}}, r.b[11:0]};
    case (r.op)
      t_add: return r.a + r.b;
      t_addi: return r.a + imm;
      t_sub: return r.a - r.b;
      t_and: return r.a & r.b;
      t_andi: return r.a & imm;
      t_or: return r.a | r.b;
      t_ori: return r.a | imm;
      t_xor: return r.a ^ r.b;
      t_xori: return r.a ^ imm;
      t_slt: return ($signed(r.a) < $signed(r.b)) ? 32'd1 : 32'd0;
      t_slti: return ($signed(r.a) < $signed(imm)) ? 32'd1 : 32'd0;
      t_sll: return r.a << r.b[4:0];
      t_srl: return r.a >> r.b[4:0];
      t_beq: taken = (r.a == r.b);
      t_bne: taken = (r.a != r.b);
      default: return 32'h0;
    endcase
    // a taken branch skips the addi that adds 2.
    return taken ? 32'd1 : 32'd3;
  endfunction

  function automatic logic [31:0] encode_r_type(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
  endfunction

  function automatic logic [31:0] encode_i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
  endfunction

  function automatic logic [31:0] encode_branch(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic emit_instr(input logic [31:0] word);
    imem[prog_pos] = word;
    prog_pos++;
  endtask

  // lui rounds up when the low 12 bits will be sign extended by addi.
  task automatic emit_load_constant(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit_instr({upper[31:12], rd, 7'b0110111});
    emit_instr(encode_i_type(value[11:0], rd, 3'b000, rd, 7'b0010011));
  endtask

  task automatic prepare_memories(input row_t r);
    for (int i = 0; i < 256; i++) begin
      imem[i] = i << 9;
      dmem[i] = 32'h5a5a_0000 | (i << 2);
    end
    if (r.load) begin
      dmem[32'h200 >> 2] = r.b;
    end
    prog_pos = reset_pc[9:2];
    emit_load_constant(5'd1, r.a);
    if (r.load) begin
      emit_instr(encode_i_type(12'h200, 5'd0, 3'b010, 5'd2, 7'b0000011));
    end else begin
      emit_load_constant(5'd2, r.b);
    end
    case (r.op)
      t_add: emit_instr(encode_r_type(7'h00, 3'b000));
      t_sub: emit_instr(encode_r_type(7'h20, 3'b000));
      t_and: emit_instr(encode_r_type(7'h00, 3'b111));
      t_or: emit_instr(encode_r_type(7'h00, 3'b110));
      t_xor: emit_instr(encode_r_type(7'h00, 3'b100));
      t_slt: emit_instr(encode_r_type(7'h00, 3'b010));
      t_sll: emit_instr(encode_r_type(7'h00, 3'b001));
      t_srl: emit_instr(encode_r_type(7'h00, 3'b101));
      t_addi: emit_instr(encode_i_type(r.b[11:0], 5'd1, 3'b000, 5'd3, 7'b0010011));
      t_andi: emit_instr(encode_i_type(r.b[11:0], 5'd1, 3'b111, 5'd3, 7'b0010011));
      t_ori: emit_instr(encode_i_type(r.b[11:0], 5'd1, 3'b110, 5'd3, 7'b0010011));
      t_xori: emit_instr(encode_i_type(r.b[11:0], 5'd1, 3'b100, 5'd3, 7'b0010011));
      t_slti: emit_instr(encode_i_type(r.b[11:0], 5'd1, 3'b010, 5'd3, 7'b0010011));
      default: begin
        emit_instr(encode_i_type(12'd1, 5'd0, 3'b000, 5'd3, 7'b0010011));
        emit_instr(encode_branch(13'd8, (r.op == t_beq) ? 3'b000 : 3'b001));
        emit_instr(encode_i_type(12'd2, 5'd3, 3'b000, 5'd3, 7'b0010011));
      end
    endcase
    emit_instr({7'h0, 5'd3, 5'd0, 3'b010, 5'h0, 7'b0100011} | (32'h100 << 20) & 32'hfe000000);
    // jal x0, 0 parks the core after the store.
    emit_instr(32'h0000_006f);
  endtask

  // instruction memory model with random waits.
  always @(posedge clock) begin
    #1;
    if (imemory_ready || !imemory_valid) begin
      imemory_ready = 1'b0;
      imem_wait = -1;
    end else begin
      check_value("imemory_wstrb", 32'h0, imemory_wstrb);
      check_value("imemory_wdata", 32'h0, imemory_wdata);
      if (imem_wait < 0) begin
        imem_wait = draw_wait();
        imem_req_addr = imemory_addr;
      end else begin
        check_value("imemory_addr", imem_req_addr, imemory_addr);
      end
      if (imem_wait == 0) begin
        imemory_rdata = imem[imemory_addr[9:2]];
        imemory_ready = 1'b1;
      end else begin
        imem_wait--;
      end
    end
  end

  // data memory model, which also records the first store of a test.
  always @(posedge clock) begin
    #1;
    if (dmemory_ready || !dmemory_valid) begin
      dmemory_ready = 1'b0;
      dmem_wait = -1;
    end else begin
      if (dmem_wait < 0) begin
        dmem_wait = draw_wait();
        dmem_req_addr = dmemory_addr;
        dmem_req_wdata = dmemory_wdata;
      end else begin
        check_value("dmemory_addr", dmem_req_addr, dmemory_addr);
        check_value("dmemory_wdata", dmem_req_wdata, dmemory_wdata);
      end
      if (dmem_wait == 0) begin
        if (dmemory_wstrb != 4'h0) begin
          dmem[dmemory_addr[9:2]] = dmemory_wdata;
          if (!store_seen) begin
            store_seen = 1'b1;
            store_addr = dmemory_addr;
            store_data = dmemory_wdata;
            store_strb = dmemory_wstrb;
          end
        end else begin
          dmemory_rdata = dmem[dmemory_addr[9:2]];
        end
        dmemory_ready = 1'b1;
      end else begin
        dmem_wait--;
      end
    end
  end

  initial begin
    row_t r;
    test_op_t op;
    int errors_before;
    rst = 1'b1;
    imemory_rdata = '0;
    imemory_ready = 1'b0;
    dmemory_rdata = '0;
    dmemory_ready = 1'b0;
    store_seen = 1'b0;
    error_count = 0;
    failed_tests = 0;
    cycles = 0;
    imem_wait = -1;
    dmem_wait = -1;

    rows[0] = make_row(t_add, 32'h1234_5fff, 32'h0000_0801, 1'b0);
    rows[1] = make_row(t_sub, 32'h0000_0003, 32'h0000_000a, 1'b0);
    rows[2] = make_row(t_and, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 1'b0);
    rows[3] = make_row(t_or, 32'h1234_0000, 32'h0000_5678, 1'b0);
    rows[4] = make_row(t_xor, 32'haaaa_5555, 32'hffff_0000, 1'b0);
    rows[5] = make_row(t_slt, 32'hffff_fff6, 32'h0000_0003, 1'b0);
    rows[6] = make_row(t_slt, 32'h0000_0005, 32'hffff_fff0, 1'b0);
    rows[7] = make_row(t_sll, 32'h0000_00f1, 32'h0000_0008, 1'b0);
    rows[8] = make_row(t_srl, 32'hf000_0000, 32'h0000_000c, 1'b0);
    rows[9] = make_row(t_addi, 32'h0000_0064, 32'hffff_fff6, 1'b0);
    rows[10] = make_row(t_andi, 32'h1234_5678, 32'h0000_0ff0, 1'b0);
    rows[11] = make_row(t_ori, 32'h1234_0000, 32'h0000_07ff, 1'b0);
    rows[12] = make_row(t_xori, 32'h0000_ffff, 32'hffff_f800, 1'b0);
    rows[13] = make_row(t_slti, 32'hffff_fff0, 32'h0000_0005, 1'b0);
    rows[14] = make_row(t_add, 32'h0000_1000, 32'h0bad_f00d, 1'b1);
    rows[15] = make_row(t_beq, 32'h0000_0007, 32'h0000_0007, 1'b0);
    rows[16] = make_row(t_beq, 32'h0000_0007, 32'h0000_0008, 1'b0);
    rows[17] = make_row(t_bne, 32'h0000_0007, 32'h0000_0008, 1'b0);
    rows[18] = make_row(t_bne, 32'h0000_0009, 32'h0000_0009, 1'b0);

    for (int t = 0; t < num_rows; t++) begin
      r = rows[t];
      op = r.op;
      errors_before = error_count;
      rst = 1'b1;
      store_seen = 1'b0;
      prepare_memories(r);
      repeat (5) begin
        @(posedge clock);
        #1;
        check_value("imemory_valid", 32'd0, imemory_valid);
        check_value("dmemory_valid", 32'd0, dmemory_valid);
      end
      rst = 1'b0;
      @(posedge clock);
      #1;
      check_value("imemory_valid", 32'd1, imemory_valid);
      check_value("imemory_addr", reset_pc, imemory_addr);
      while (!store_seen) begin
        @(posedge clock);
        #1;
      end
      check_value("dmemory_addr", 32'h100, store_addr);
      check_value("dmemory_wstrb", 32'hf, store_strb);
      check_value("dmemory_wdata", expected_result(r), store_data);
      if (error_count == errors_before) begin
        $display("test %0d %s a=%h b=%h load=%0d: passed", t, op.name(), r.a, r.b, r.load);
      end else begin
        failed_tests++;
        $display("test %0d %s a=%h b=%h load=%0d: failed", t, op.name(), r.a, r.b, r.load);
      end
    end

    $display("%0d tests, %0d passed, %0d failed, %0d check errors", num_rows,
             num_rows - failed_tests, failed_tests, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* filelist.f */
hdl/cpu_pkg.sv
hdl/decoder.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/result_unit.sv
hdl/sequencer.sv
hdl/cpu.sv
bench/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - hdl/cpu_pkg.sv
  - hdl/decoder.sv
  - hdl/register_file.sv
  - hdl/execute_unit.sv
  - hdl/result_unit.sv
  - hdl/sequencer.sv
  - hdl/cpu.sv
  - target: test
    files:
      - bench/cpu_tb.sv
